// ==== hdmi_tx_config.f ====
hw/hdmi_tx_pkg.sv
hw/hdmi_init_table.sv
hw/i2c_transaction.sv
hw/cts_tracker.sv
hw/hdmi_tx_ctrl.sv
hw/hdmi_tx_config.sv
verification/hdmi_tx_config_tb.sv

// ==== hw/cts_tracker.sv ====
module cts_tracker (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    sample,
    input  hdmi_tx_pkg::reg_data_t  value,
    input  logic                    window_clear,
    output hdmi_tx_pkg::cts_stats_t stats
);

    always_ff @(posedge clk) begin
        if (!reset) begin
            stats <= '0;
        end else begin
            if (sample) begin
                stats.current <= value;
                if (value >= stats.maximum) begin
                    stats.maximum <= value;
                end
                // offset is the deepest drop below the running maximum
                if (stats.maximum > value && (stats.maximum - value) > stats.offset) begin
                    stats.offset <= stats.maximum - value;
                end
            end
            // close the window, keep its final offset
            if (window_clear) begin
                stats.window_offset <= stats.offset;
                stats.maximum       <= '0;
                stats.offset        <= '0;
            end
        end
    end

endmodule

// ==== hw/hdmi_init_table.sv ====
module hdmi_init_table #(
    parameter bit aspect_16_9 = 1'b0
) (
    input  logic [4:0]               step,
    output hdmi_tx_pkg::init_entry_t entry
);
    import hdmi_tx_pkg::*;

    // bit 1 of register 0x17 selects a 16:9 input aspect ratio
    localparam reg_data_t ASPECT_BITS = aspect_16_9 ? 8'h02 : 8'h00;

    always_comb begin
        case (step)
            // power up all circuits
            5'd0:    entry = '{8'h41, 8'h10};
            // fixed registers
            5'd1:    entry = '{8'h98, 8'h03};
            5'd2:    entry = '{8'h9A, 8'hE0};
            5'd3:    entry = '{8'h9C, 8'h30};
            5'd4:    entry = '{8'h9D, 8'h01};
            5'd5:    entry = '{8'hA2, 8'hA4};
            5'd6:    entry = '{8'hA3, 8'hA4};
            5'd7:    entry = '{8'hE0, 8'hD0};
            5'd8:    entry = '{8'hF9, 8'h00};
            // 44.1 kHz audio, 24 bit RGB 4:4:4 with separate syncs
            5'd9:    entry = '{8'h15, 8'h00};
            5'd10:   entry = '{8'h17, 8'h00 | ASPECT_BITS};
            // 4:4:4 output at 8 bit colour depth
            5'd11:   entry = '{8'h16, 8'h30};
            // RGB in the AVI infoframe, colour space converter off
            5'd12:   entry = '{8'h55, 8'h00};
            5'd13:   entry = '{8'h18, 8'h46};
            // HDMI mode, no HDCP
            5'd14:   entry = '{8'hAF, 8'h06};
            5'd15:   entry = '{8'hBA, 8'h60};
            // automatic CTS, I2S audio
            5'd16:   entry = '{8'h0A, 8'h00};
            // N value 0x1880 for 44.1 kHz
            5'd17:   entry = '{8'h01, 8'h00};
            5'd18:   entry = '{8'h02, 8'h18};
            5'd19:   entry = '{8'h03, 8'h80};
            5'd20:   entry = '{8'h0B, 8'h0E};
            // I2S0 only, right justified, 16 bit samples
            5'd21:   entry = '{8'h0C, 8'h05};
            5'd22:   entry = '{8'h0D, 8'h10};
            // enable hot plug and monitor sense interrupts, then clear them
            5'd23:   entry = '{8'h94, 8'hC0};
            5'd24:   entry = '{8'h96, 8'hC0};
            5'd25:   entry = '{8'h3B, 8'h80};
            5'd26:   entry = '{8'h3C, 8'h00};
            default: entry = '0;
        endcase
    end

endmodule

// ==== hw/hdmi_tx_config.sv ====
module hdmi_tx_config #(
    parameter bit aspect_16_9  = 1'b0,
    parameter int frame_window = 1024
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      hdmi_int,
    input  logic                      vsync,
    input  logic                      de,
    output hdmi_tx_pkg::i2c_req_t     i2c_req,
    output logic                      i2c_enable,
    input  hdmi_tx_pkg::i2c_rsp_t     i2c_rsp,
    output logic                      ready,
    output hdmi_tx_pkg::link_status_t link_status,
    output hdmi_tx_pkg::cts_stats_t   cts1_stats,
    output hdmi_tx_pkg::cts_stats_t   cts2_stats,
    output hdmi_tx_pkg::cts_stats_t   cts3_stats
);
    import hdmi_tx_pkg::*;

    logic [4:0]  step;
    init_entry_t entry;
    logic        cmd_valid;
    i2c_req_t    cmd;
    logic        cmd_done;
    logic        cmd_ack_error;
    reg_data_t   rd_data;
    logic [2:0]  cts_sample;
    logic        window_clear;

    hdmi_tx_ctrl #(
        .frame_window (frame_window)
    ) hdmi_tx_ctrl_inst (
        .clk           (clk),
        .reset         (reset),
        .hdmi_int      (hdmi_int),
        .vsync         (vsync),
        .de            (de),
        .step          (step),
        .entry         (entry),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .cmd_done      (cmd_done),
        .cmd_ack_error (cmd_ack_error),
        .rd_data       (rd_data),
        .cts_sample    (cts_sample),
        .window_clear  (window_clear),
        .ready         (ready),
        .link_status   (link_status)
    );

    hdmi_init_table #(
        .aspect_16_9 (aspect_16_9)
    ) hdmi_init_table_inst (
        .step  (step),
        .entry (entry)
    );

    i2c_transaction i2c_transaction_inst (
        .clk           (clk),
        .reset         (reset),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .cmd_done      (cmd_done),
        .cmd_ack_error (cmd_ack_error),
        .rd_data       (rd_data),
        .i2c_req       (i2c_req),
        .i2c_enable    (i2c_enable),
        .i2c_rsp       (i2c_rsp)
    );

    // one tracker per CTS byte, registers 0x04 to 0x06
    cts_tracker cts1_tracker_inst (
        .clk          (clk),
        .reset        (reset),
        .sample       (cts_sample[0]),
        .value        (rd_data),
        .window_clear (window_clear),
        .stats        (cts1_stats)
    );

    cts_tracker cts2_tracker_inst (
        .clk          (clk),
        .reset        (reset),
        .sample       (cts_sample[1]),
        .value        (rd_data),
        .window_clear (window_clear),
        .stats        (cts2_stats)
    );

    cts_tracker cts3_tracker_inst (
        .clk          (clk),
        .reset        (reset),
        .sample       (cts_sample[2]),
        .value        (rd_data),
        .window_clear (window_clear),
        .stats        (cts3_stats)
    );

endmodule

// ==== hw/hdmi_tx_ctrl.sv ====
module hdmi_tx_ctrl #(
    parameter int frame_window = 1024
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      hdmi_int,
    input  logic                      vsync,
    input  logic                      de,
    output logic [4:0]                step,
    input  hdmi_tx_pkg::init_entry_t  entry,
    output logic                      cmd_valid,
    output hdmi_tx_pkg::i2c_req_t     cmd,
    input  logic                      cmd_done,
    input  logic                      cmd_ack_error,
    input  hdmi_tx_pkg::reg_data_t    rd_data,
    output logic [2:0]                cts_sample,
    output logic                      window_clear,
    output logic                      ready,
    output hdmi_tx_pkg::link_status_t link_status
);
    import hdmi_tx_pkg::*;

    localparam logic [4:0] INIT_LAST  = 5'(INIT_STEPS - 1);
    localparam logic [4:0] SWEEP_LAST = 5'd9;
    localparam int         FRAME_W    = $clog2(frame_window + 1);

    typedef enum logic [1:0] {
        S_ISSUE,
        S_WAIT,
        S_IDLE
    } state_t;

    typedef enum logic [1:0] {
        OP_INIT,
        OP_PLL,
        OP_SWEEP,
        OP_CTS3
    } op_t;

    state_t             state;
    op_t                op;
    logic [4:0]         idx;
    logic               vsync_q;
    logic               de_q;
    logic [FRAME_W-1:0] frame_count;
    reg_addr_t          sweep_addr;

    assign step = idx;

    // status sweep order
    always_comb begin
        case (idx)
            5'd0:    sweep_addr = REG_REVISION;
            5'd1:    sweep_addr = REG_ID_HIGH;
            5'd2:    sweep_addr = REG_ID_LOW;
            5'd3:    sweep_addr = REG_PLL;
            5'd4:    sweep_addr = REG_CTS1;
            5'd5:    sweep_addr = REG_CTS2;
            5'd6:    sweep_addr = REG_CTS3;
            5'd7:    sweep_addr = REG_VIC_DETECTED;
            5'd8:    sweep_addr = REG_VIC_TO_RX;
            default: sweep_addr = REG_MISC;
        endcase
    end

    always_comb begin
        cmd.chip_addr = CHIP_ADDR;
        cmd.value     = '0;
        cmd.is_read   = 1'b1;
        case (op)
            OP_INIT: begin
                cmd.reg_addr = entry.addr;
                cmd.value    = entry.value;
                cmd.is_read  = 1'b0;
            end
            OP_PLL: begin
                cmd.reg_addr = REG_PLL;
            end
            OP_SWEEP: begin
                cmd.reg_addr = sweep_addr;
            end
            default: begin
                cmd.reg_addr = REG_CTS3;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state        <= S_ISSUE;
            op           <= OP_INIT;
            idx          <= '0;
            ready        <= 1'b0;
            cmd_valid    <= 1'b0;
            cts_sample   <= '0;
            window_clear <= 1'b0;
            vsync_q      <= 1'b0;
            de_q         <= 1'b0;
            frame_count  <= '0;
            link_status  <= '0;
        end else begin
            vsync_q      <= vsync;
            de_q         <= de;
            cmd_valid    <= 1'b0;
            cts_sample   <= '0;
            window_clear <= 1'b0;
            case (state)
                S_ISSUE: begin
                    cmd_valid <= 1'b1;
                    state     <= S_WAIT;
                end
                S_WAIT: begin
                    // an ack error leaves op and idx alone, so the same access goes again
                    if (cmd_done) begin
                        state <= S_ISSUE;
                        if (!cmd_ack_error) begin
                            case (op)
                                OP_INIT: begin
                                    if (idx == INIT_LAST) begin
                                        op  <= OP_PLL;
                                        idx <= '0;
                                    end else begin
                                        idx <= idx + 1'b1;
                                    end
                                end
                                OP_PLL: begin
                                    if (rd_data[PLL_LOCK_BIT]) begin
                                        ready <= 1'b1;
                                        state <= S_IDLE;
                                    end else begin
                                        // not locked, start the write list over
                                        link_status.pll_errors <= link_status.pll_errors + 1'b1;
                                        op                     <= OP_INIT;
                                    end
                                end
                                OP_SWEEP: begin
                                    case (idx)
                                        5'd0: link_status.revision <= rd_data;
                                        5'd1: link_status.id_high <= rd_data;
                                        5'd2: link_status.id_low <= rd_data;
                                        5'd3: begin
                                            link_status.pll_status <= rd_data;
                                            if (!rd_data[PLL_LOCK_BIT]) begin
                                                link_status.pll_errors <=
                                                    link_status.pll_errors + 1'b1;
                                            end
                                        end
                                        5'd4: cts_sample[0] <= 1'b1;
                                        5'd5: cts_sample[1] <= 1'b1;
                                        5'd6: cts_sample[2] <= 1'b1;
                                        5'd7: link_status.vic_detected <= rd_data;
                                        5'd8: link_status.vic_to_rx <= rd_data;
                                        default: link_status.misc <= rd_data;
                                    endcase
                                    if (idx == SWEEP_LAST) begin
                                        state <= S_IDLE;
                                    end else begin
                                        idx <= idx + 1'b1;
                                    end
                                end
                                default: begin
                                    cts_sample[2] <= 1'b1;
                                    state         <= S_IDLE;
                                end
                            endcase
                        end
                    end
                end
                default: begin
                    // events are only taken here, anything during a transaction is lost
                    if (!hdmi_int) begin
                        ready <= 1'b0;
                        op    <= OP_INIT;
                        idx   <= '0;
                        state <= S_ISSUE;
                    end else if (de && !de_q) begin
                        op    <= OP_CTS3;
                        state <= S_ISSUE;
                    end else if (vsync && !vsync_q) begin
                        op          <= OP_SWEEP;
                        idx         <= '0;
                        state       <= S_ISSUE;
                        frame_count <= frame_count + 1'b1;
                    end
                    // window closes once the sweep of its last vsync is done
                    if (frame_count == FRAME_W'(frame_window)) begin
                        window_clear <= 1'b1;
                        frame_count  <= '0;
                    end
                end
            endcase
        end
    end

endmodule

// ==== hw/hdmi_tx_pkg.sv ====
package hdmi_tx_pkg;

    // transmitter address on the register bus
    localparam logic [6:0] CHIP_ADDR = 7'h39;

    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    // one register access towards the bus engine
    typedef struct packed {
        logic [6:0] chip_addr;
        reg_addr_t  reg_addr;
        reg_data_t  value;
        logic       is_read;
    } i2c_req_t;

    // done is a level, high while the engine is idle
    typedef struct packed {
        reg_data_t data;
        logic      done;
        logic      ack_error;
    } i2c_rsp_t;

    typedef struct packed {
        reg_addr_t addr;
        reg_data_t value;
    } init_entry_t;

    localparam int INIT_STEPS   = 27;
    localparam int PLL_LOCK_BIT = 4;

    // status registers
    localparam reg_addr_t REG_REVISION     = 8'h00;
    localparam reg_addr_t REG_CTS1         = 8'h04;
    localparam reg_addr_t REG_CTS2         = 8'h05;
    localparam reg_addr_t REG_CTS3         = 8'h06;
    localparam reg_addr_t REG_VIC_TO_RX    = 8'h3D;
    localparam reg_addr_t REG_VIC_DETECTED = 8'h3E;
    localparam reg_addr_t REG_MISC         = 8'h42;
    localparam reg_addr_t REG_PLL          = 8'h9E;
    localparam reg_addr_t REG_ID_HIGH      = 8'hF5;
    localparam reg_addr_t REG_ID_LOW       = 8'hF6;

    typedef struct packed {
        reg_data_t current;
        reg_data_t maximum;
        reg_data_t offset;
        reg_data_t window_offset;
    } cts_stats_t;

    typedef struct packed {
        reg_data_t revision;
        reg_data_t id_high;
        reg_data_t id_low;
        reg_data_t pll_status;
        reg_data_t pll_errors;
        reg_data_t vic_detected;
        reg_data_t vic_to_rx;
        reg_data_t misc;
    } link_status_t;

endpackage

// ==== hw/i2c_transaction.sv ====
module i2c_transaction (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cmd_valid,
    input  hdmi_tx_pkg::i2c_req_t  cmd,
    output logic                   cmd_done,
    output logic                   cmd_ack_error,
    output hdmi_tx_pkg::reg_data_t rd_data,
    output hdmi_tx_pkg::i2c_req_t  i2c_req,
    output logic                   i2c_enable,
    input  hdmi_tx_pkg::i2c_rsp_t  i2c_rsp
);

    typedef enum logic [1:0] {
        T_IDLE,
        T_SETTLE,
        T_WAIT
    } txn_state_t;

    txn_state_t state;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state         <= T_IDLE;
            i2c_enable    <= 1'b0;
            cmd_done      <= 1'b0;
            cmd_ack_error <= 1'b0;
        end else begin
            i2c_enable <= 1'b0;
            cmd_done   <= 1'b0;
            case (state)
                T_IDLE: begin
                    if (cmd_valid) begin
                        i2c_enable <= 1'b1;
                        state      <= T_SETTLE;
                    end
                end
                // the engine needs a cycle to drop done after the enable
                T_SETTLE: begin
                    state <= T_WAIT;
                end
                T_WAIT: begin
                    if (i2c_rsp.done) begin
                        cmd_done      <= 1'b1;
                        cmd_ack_error <= i2c_rsp.ack_error;
                        state         <= T_IDLE;
                    end
                end
                default: begin
                    state <= T_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == T_IDLE && cmd_valid) begin
            i2c_req <= cmd;
        end
        // read data stays valid until the next read completes
        if (state == T_WAIT && i2c_rsp.done && i2c_req.is_read) begin
            rd_data <= i2c_rsp.data;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module hdmi_tx_config_tb -f hdmi_tx_config.f

output=$(./obj_dir/Vhdmi_tx_config_tb 2>&1) || true
echo "$output"

if echo "$output" | grep -q "=== PASS ==="; then
    exit 0
fi
exit 1

// ==== verification/hdmi_tx_config_tb.sv ====
module hdmi_tx_config_tb;
    timeunit 1ns;
    timeprecision 1ns;

    import hdmi_tx_pkg::*;

    logic         clk;
    logic         reset;
    logic         hdmi_int;
    logic         vsync;
    logic         de;
    i2c_req_t     i2c_req;
    logic         i2c_enable;
    i2c_rsp_t     i2c_rsp;
    logic         ready;
    link_status_t link_status;
    cts_stats_t   cts1_stats;
    cts_stats_t   cts2_stats;
    cts_stats_t   cts3_stats;

    // bus engine model state
    // done belongs to the capture process
    logic       rsp_done = 1'b1;
    reg_data_t  rsp_data;
    logic       rsp_ack;
    logic       release_rsp;
    i2c_req_t   req_queue[$];
    reg_data_t  chip_regs[256];

    logic [7:0]  vec_op[$];
    logic [63:0] vec_a[$];
    logic [63:0] vec_b[$];
    logic        vectors_loaded = 1'b0;
    int unsigned lcg_state = 77;

    // expected write list with the 16:9 aspect bit in register 0x17
    logic [15:0] init_list [27] = '{
        16'h4110, 16'h9803, 16'h9AE0, 16'h9C30, 16'h9D01, 16'hA2A4, 16'hA3A4, 16'hE0D0, 16'hF900,
        16'h1500, 16'h1702, 16'h1630, 16'h5500, 16'h1846, 16'hAF06, 16'hBA60, 16'h0A00, 16'h0100,
        16'h0218, 16'h0380, 16'h0B0E, 16'h0C05, 16'h0D10, 16'h94C0, 16'h96C0, 16'h3B80, 16'h3C00
    };

    reg_addr_t sweep_list [10] = '{
        8'h00, 8'hF5, 8'hF6, 8'h9E, 8'h04, 8'h05, 8'h06, 8'h3E, 8'h3D, 8'h42
    };

    assign i2c_rsp = '{data: rsp_data, done: rsp_done, ack_error: rsp_ack};

    hdmi_tx_config #(
        .aspect_16_9  (1'b1),
        .frame_window (4)
    ) hdmi_tx_config_inst (
        .clk         (clk),
        .reset       (reset),
        .hdmi_int    (hdmi_int),
        .vsync       (vsync),
        .de          (de),
        .i2c_req     (i2c_req),
        .i2c_enable  (i2c_enable),
        .i2c_rsp     (i2c_rsp),
        .ready       (ready),
        .link_status (link_status),
        .cts1_stats  (cts1_stats),
        .cts2_stats  (cts2_stats),
        .cts3_stats  (cts3_stats)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic fail_run();
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("Error %s expected %h got %h", name, expected, actual);
            fail_run();
        end
    endtask

    // enough cycles for done, cmd_done, the controller and the trackers to finish
    task automatic settle();
        repeat (6) @(posedge clk);
    endtask

    // capture every request and drop done until the player answers
    always @(posedge clk) begin
        if (i2c_enable) begin
            req_queue.push_back(i2c_req);
            rsp_done <= 1'b0;
        end else if (release_rsp) begin
            rsp_done <= 1'b1;
        end
    end

    task automatic serve_request(input bit is_read, input reg_addr_t addr,
                                 input reg_data_t value, input bit ack_error);
        i2c_req_t req;
        int       delay;
        while (req_queue.size() == 0) @(posedge clk);
        req = req_queue.pop_front();
        check_value("i2c_req.chip_addr", 64'h39, 64'(req.chip_addr));
        check_value("i2c_req.is_read", 64'(is_read), 64'(req.is_read));
        check_value("i2c_req.reg_addr", 64'(addr), 64'(req.reg_addr));
        if (!is_read) begin
            check_value("i2c_req.value", 64'(value), 64'(req.value));
            if (!ack_error) begin
                chip_regs[addr] = value;
            end
        end
        delay = 2 + int'((lcg_next() >> 16) % 8);
        repeat (delay) @(posedge clk);
        rsp_data    <= is_read ? chip_regs[addr] : 8'h00;
        rsp_ack     <= ack_error;
        release_rsp <= 1'b1;
        @(posedge clk);
        release_rsp <= 1'b0;
    endtask

    // events are only seen by an idle controller, so wait before each one
    task automatic drive_event(input logic [7:0] op);
        settle();
        case (op)
            "V": vsync <= 1'b1;
            "D": de <= 1'b1;
            default: hdmi_int <= 1'b0;
        endcase
        @(posedge clk);
        vsync    <= 1'b0;
        de       <= 1'b0;
        hdmi_int <= 1'b1;
    endtask

    task automatic check_output(input logic [63:0] sel, input logic [63:0] expected);
        settle();
        @(negedge clk);
        case (sel)
            0: check_value("ready", expected, 64'(ready));
            1: check_value("link_status", expected, link_status);
            2: check_value("cts1_stats", expected, 64'(cts1_stats));
            3: check_value("cts2_stats", expected, 64'(cts2_stats));
            4: check_value("cts3_stats", expected, 64'(cts3_stats));
            default: begin
                $display("a check vector names an unknown output %0d", sel);
                fail_run();
            end
        endcase
    endtask

    task automatic play_vector(input logic [7:0] op, input logic [63:0] a,
                               input logic [63:0] b);
        case (op)
            "L": begin
                for (int s = int'(a); s <= int'(b); s++) begin
                    serve_request(1'b0, init_list[s][15:8], init_list[s][7:0], 1'b0);
                end
            end
            "A": serve_request(1'b0, a[7:0], b[7:0], 1'b1);
            "R": begin
                chip_regs[a[7:0]] = b[7:0];
                serve_request(1'b1, a[7:0], 8'h00, 1'b0);
            end
            "P": chip_regs[a[7:0]] = b[7:0];
            "S": begin
                foreach (sweep_list[i]) begin
                    serve_request(1'b1, sweep_list[i], 8'h00, 1'b0);
                end
            end
            "V", "D", "I": drive_event(op);
            "C": check_output(a, b);
            default: begin
                $display("the vector file holds an unknown opcode %c", op);
                fail_run();
            end
        endcase
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [63:0] a;
        logic [63:0] b;
        fd = $fopen("verification/hdmi_tx_config_vectors.txt", "r");
        if (fd == 0) begin
            $display("the vector file could not be opened");
            fail_run();
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            a = '0;
            b = '0;
            // skip comments and blank lines
            if (n > 0 && line[0] != "#" && line[0] != "\n" && line[0] != "\r") begin
                n = $sscanf(line, "%c %h %h", op, a, b);
                vec_op.push_back(op);
                vec_a.push_back(a);
                vec_b.push_back(b);
            end
        end
        $fclose(fd);
        vectors_loaded = 1'b1;
    endtask

    initial begin
        reset       = 1'b0;
        hdmi_int    = 1'b1;
        vsync       = 1'b0;
        de          = 1'b0;
        rsp_data    = 8'h00;
        rsp_ack     = 1'b0;
        release_rsp = 1'b0;
        // chip registers start with a pattern of their own address
        for (int i = 0; i < 256; i++) begin
            chip_regs[i] = 8'(i) ^ 8'hA5;
        end
        load_vectors();
        repeat (2) @(posedge clk);
        reset <= 1'b1;
        foreach (vec_op[i]) begin
            play_vector(vec_op[i], vec_a[i], vec_b[i]);
        end
        $display("=== PASS ===");
        $finish;
    end

    initial begin
        wait (vectors_loaded);
        repeat (vec_op.size() * 400) @(posedge clk);
        $display("the run timed out before all vectors were played");
        fail_run();
    end

endmodule

// ==== verification/hdmi_tx_config_vectors.txt ====
# op a b, hex. L first last: init writes. A reg val: write answered with ack error
# R reg data: read. P reg data: chip register. S: sweep. V D I: vsync de interrupt
# C sel value: output check, sel 0 ready, 1 link_status, 2 to 4 cts1 to cts3 stats
C 0 0
L 00 03
A 9D 01
L 04 1A
R 9E 00
L 00 1A
R 9E 10
C 0 1
C 1 0000000001000000
P 04 40
P 05 80
P 06 20
V
S
C 1 A5505310019B98E7
D
R 06 28
P 04 30
P 05 60
P 06 18
V
S
D
R 06 10
C 2 30401000
C 3 60802000
C 4 10281800
P 04 50
P 05 70
P 06 24
P 9E 00
V
S
C 1 A5505300029B98E7
D
R 06 26
P 04 48
P 05 90
P 06 22
P 9E 10
V
S
C 1 A5505310029B98E7
C 2 48000010
C 3 90000020
C 4 22000018
I
C 0 0
L 00 1A
R 9E 10
C 0 1
